//--- sim.f
common/spif_pkg.sv
logic/cfg_reg_bank.sv
logic/evt_mapper.sv
logic/pkt_rr_arbiter.sv
pkt_router/pkt_router.sv
logic/dvs_spif_top.sv
dv/spif_tb.sv

//--- Makefile
# Verilator build and run for the spif event path testbench

SRCS := $(shell cat sim.f)

run: obj_dir/spif_tb
	./obj_dir/spif_tb | tee sim.log
	@if grep -q "Done: errors found" sim.log; then echo "FAIL"; exit 1; fi
	@grep -q "Done: no errors" sim.log || (echo "FAIL"; exit 1)
	@echo "PASS"

# rebuilt only when a source or the file list changes
obj_dir/spif_tb: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module spif_tb -o spif_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- dv/spif_tb.sv
/*
  testbench for the dvs to spinnaker event path
  random events on both pipes, checked against a model of the
  mapper and first-match router rules. covers link-down swallowing,
  channel back-pressure and round-robin fairness on one channel
*/

`timescale 1ns/1ns
`default_nettype none

module spif_tb;

  localparam int NUM_RT   = 4;
  localparam int SFT_BITS = 5;
  localparam int N_RAND   = 120;
  localparam int N_LINK   = 40;
  localparam int N_ALT    = 60;
  // events over all phases and both pipes
  localparam int N_TOTAL   = 2 * (2 * N_RAND + N_LINK + N_ALT);
  localparam int WD_CYCLES = N_TOTAL * 20;
  // longest path from the last output to the drop counter
  localparam int DRAIN_CYCLES = 8;

  logic                tl_freerun_clk_int;
  logic                tl_reset_all_int;
  logic                link_up;
  spif_pkg::evt_t      evt_data [2];
  logic [1:0]          evt_vld;
  logic [1:0]          evt_rdy;
  logic                cfg_wr_en;
  spif_pkg::reg_addr_t cfg_addr;
  spif_pkg::reg_data_t cfg_wdata;
  spif_pkg::pkt_key_t  chan_data [2];
  logic [1:0]          chan_vld;
  logic [1:0]          chan_rdy;
  spif_pkg::drop_cnt_t drop_count;

  // model copies of the configuration
  spif_pkg::pkt_key_t  m_key [2];
  spif_pkg::pkt_key_t  m_msk [2];
  logic [SFT_BITS-1:0] m_sft [2];
  spif_pkg::pkt_key_t  t_key [NUM_RT];
  spif_pkg::pkt_key_t  t_msk [NUM_RT];
  logic                t_rte [NUM_RT];
  // expected keys indexed by 2 * pipe + channel
  spif_pkg::pkt_key_t  exp_q [4][$];
  int                  exp_drops;
  logic                bp_on;
  logic                alt_on;
  int                  alt_prev;
  int unsigned         seed_val;

  dvs_spif_top #(
    .num_rt_entries (NUM_RT),
    .mp_shift_bits  (SFT_BITS)
  ) i_dvs_spif_top (
    .tl_freerun_clk_int (tl_freerun_clk_int),
    .tl_reset_all_int   (tl_reset_all_int),
    .link_up            (link_up),
    .evt_data_0         (evt_data[0]),
    .evt_vld_0          (evt_vld[0]),
    .evt_rdy_0          (evt_rdy[0]),
    .evt_data_1         (evt_data[1]),
    .evt_vld_1          (evt_vld[1]),
    .evt_rdy_1          (evt_rdy[1]),
    .cfg_wr_en          (cfg_wr_en),
    .cfg_addr           (cfg_addr),
    .cfg_wdata          (cfg_wdata),
    .chan_data_0        (chan_data[0]),
    .chan_vld_0         (chan_vld[0]),
    .chan_rdy_0         (chan_rdy[0]),
    .chan_data_1        (chan_data[1]),
    .chan_vld_1         (chan_vld[1]),
    .chan_rdy_1         (chan_rdy[1]),
    .drop_count         (drop_count)
  );

  initial
  begin
    tl_freerun_clk_int = 1'b0;
    forever #4 tl_freerun_clk_int = ~tl_freerun_clk_int;
  end

  // --------------------
  // checking helpers
  // --------------------
  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // event to key by mask, right shift and pipe key merge
  function automatic spif_pkg::pkt_key_t map_event(input int p, input spif_pkg::evt_t evt);
    return ((evt & m_msk[p]) >> m_sft[p]) | m_key[p];
  endfunction

  // first entry in index order wins
  function automatic logic route_lookup(input spif_pkg::pkt_key_t key, output logic ch);
    logic found;
    found = 1'b0;
    ch    = 1'b0;
    for (int e = 0; e < NUM_RT; e++)
    begin
      if (!found && ((key & t_msk[e]) == t_key[e]))
      begin
        found = 1'b1;
        ch    = t_rte[e];
      end
    end
    return found;
  endfunction

  // --------------------
  // stimulus tasks
  // --------------------
  task automatic write_cfg(input spif_pkg::reg_addr_t addr, input spif_pkg::reg_data_t data);
    @(posedge tl_freerun_clk_int);
    cfg_wr_en <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge tl_freerun_clk_int);
    cfg_wr_en <= 1'b0;
  endtask

  // bit 31 of the key marks pipe 1 and no masked event bit reaches it
  task automatic load_mappers();
    for (int p = 0; p < 2; p++)
    begin
      m_key[p] = ($urandom & 32'h7ff0_0000) | ((p == 1) ? 32'h8000_0000 : 32'h0);
      m_msk[p] = $urandom & 32'h7fff_ffff;
      m_sft[p] = SFT_BITS'($urandom % 8);
      write_cfg(spif_pkg::reg_addr_t'(spif_pkg::MP_KEY_BASE + p), m_key[p]);
      write_cfg(spif_pkg::reg_addr_t'(spif_pkg::MP_MSK_BASE + p), m_msk[p]);
      write_cfg(spif_pkg::reg_addr_t'(spif_pkg::MP_SFT_BASE + p), 32'(m_sft[p]));
    end
  endtask

  // small 2-bit fields so that both hits and misses happen
  task automatic load_table_random();
    for (int e = 0; e < NUM_RT; e++)
    begin
      t_msk[e] = 32'h3 << (2 * ($urandom % 3));
      t_key[e] = $urandom & t_msk[e];
      t_rte[e] = 1'($urandom % 2);
      write_cfg(spif_pkg::reg_addr_t'(spif_pkg::RT_KEY_BASE + e), t_key[e]);
      write_cfg(spif_pkg::reg_addr_t'(spif_pkg::RT_MSK_BASE + e), t_msk[e]);
      write_cfg(spif_pkg::reg_addr_t'(spif_pkg::RT_RTE_BASE + e), 32'(t_rte[e]));
    end
  endtask

  // entry 0 catches everything for channel 0
  task automatic load_table_ch0();
    t_key[0] = '0;
    t_msk[0] = '0;
    t_rte[0] = 1'b0;
    write_cfg(spif_pkg::RT_KEY_BASE, 32'h0);
    write_cfg(spif_pkg::RT_MSK_BASE, 32'h0);
    write_cfg(spif_pkg::RT_RTE_BASE, 32'h0);
  endtask

  task automatic drive_pipe(input int p, input int n, input int gap_max);
    int gap;
    @(posedge tl_freerun_clk_int);
    for (int i = 0; i < n; i++)
    begin
      gap = $urandom % (gap_max + 1);
      repeat (gap) @(posedge tl_freerun_clk_int);
      evt_data[p] <= $urandom;
      evt_vld[p]  <= 1'b1;
      // hold until the handshake
      do
        @(negedge tl_freerun_clk_int);
      while (!evt_rdy[p]);
      @(posedge tl_freerun_clk_int);
      evt_vld[p] <= 1'b0;
    end
  endtask

  // all queues drained and the last unmatched packet counted
  task automatic wait_idle();
    do
      @(negedge tl_freerun_clk_int);
    while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0);
    repeat (DRAIN_CYCLES) @(negedge tl_freerun_clk_int);
    check_value("drop_count", drop_count, exp_drops);
  endtask

  // channel back-pressure with about one stall in four
  always @(posedge tl_freerun_clk_int)
  begin
    if (bp_on)
    begin
      chan_rdy[0] <= ($urandom % 4) != 0;
      chan_rdy[1] <= ($urandom % 4) != 0;
    end
    else
      chan_rdy <= 2'b11;
  end

  // --------------------
  // model and output checker
  // --------------------
  always @(negedge tl_freerun_clk_int)
  begin : model_check
    spif_pkg::pkt_key_t key;
    logic ch;
    logic hit;
    int p;
    if (!tl_reset_all_int)
    begin
      // accepted events (swallowed while the link is down)
      for (int i = 0; i < 2; i++)
      begin
        // always ready while the link is down
        if (!link_up)
          check_value($sformatf("evt_rdy_%0d", i), evt_rdy[i], 1);
        if (evt_vld[i] && evt_rdy[i] && link_up)
        begin
          key = map_event(i, evt_data[i]);
          hit = route_lookup(key, ch);
          if (hit)
            exp_q[2 * i + int'(ch)].push_back(key);
          else
            exp_drops++;
        end
      end
      for (int c = 0; c < 2; c++)
      begin
        if (chan_vld[c] && chan_rdy[c])
        begin
          p = int'(chan_data[c][31]);
          if (exp_q[2 * p + c].size() == 0)
          begin
            $display("unexpected packet %h on channel %0d at %0t", chan_data[c], c, $time);
            abort_run();
          end
          else
            check_value($sformatf("chan_data_%0d", c), chan_data[c],
                        exp_q[2 * p + c].pop_front());
          // pipes must take turns on channel 0
          if (alt_on && (c == 0))
          begin
            if (alt_prev >= 0)
              check_value("chan_data_0 pipe", p, 1 - alt_prev);
            alt_prev = p;
          end
        end
      end
    end
  end

  initial
  begin
    repeat (WD_CYCLES) @(posedge tl_freerun_clk_int);
    $display("watchdog timeout, traffic not finished after %0d cycles", WD_CYCLES);
    abort_run();
  end

  // --------------------
  // test sequence
  // --------------------
  initial
  begin
    seed_val         = $urandom(32'h9fa9_9fb6);
    tl_reset_all_int = 1'b1;
    link_up          = 1'b0;
    evt_data[0]      = '0;
    evt_data[1]      = '0;
    evt_vld          = '0;
    cfg_wr_en        = 1'b0;
    cfg_addr         = '0;
    cfg_wdata        = '0;
    chan_rdy         = 2'b11;
    bp_on            = 1'b0;
    alt_on           = 1'b0;
    alt_prev         = -1;
    exp_drops        = 0;
    repeat (3) @(posedge tl_freerun_clk_int);
    tl_reset_all_int <= 1'b0;

    // quiet after reset
    repeat (2) @(negedge tl_freerun_clk_int);
    check_value("chan_vld_0", chan_vld[0], 0);
    check_value("chan_vld_1", chan_vld[1], 0);
    check_value("drop_count", drop_count, 0);

    // random traffic with the link up
    @(posedge tl_freerun_clk_int);
    link_up <= 1'b1;
    load_mappers();
    load_table_random();
    fork
      drive_pipe(0, N_RAND, 3);
      drive_pipe(1, N_RAND, 3);
    join
    wait_idle();

    // link down so events vanish without drops
    @(posedge tl_freerun_clk_int);
    link_up <= 1'b0;
    fork
      drive_pipe(0, N_LINK, 2);
      drive_pipe(1, N_LINK, 2);
    join
    wait_idle();

    // link back up with a new table and channel back-pressure
    @(posedge tl_freerun_clk_int);
    link_up <= 1'b1;
    load_table_random();
    @(negedge tl_freerun_clk_int);
    bp_on = 1'b1;
    fork
      drive_pipe(0, N_RAND, 3);
      drive_pipe(1, N_RAND, 3);
    join
    wait_idle();

    // both pipes streaming into channel 0
    bp_on = 1'b0;
    load_table_ch0();
    alt_prev = -1;
    alt_on   = 1'b1;
    fork
      drive_pipe(0, N_ALT, 0);
      drive_pipe(1, N_ALT, 0);
    join
    wait_idle();
    alt_on = 1'b0;

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/dvs_spif_top.sv
/*
  dvs to spinnaker event path
  two event mappers share the router bus through a round-robin
  arbiter; the router steers packets to two link channels
*/

`timescale 1ns/1ns
`default_nettype none

module dvs_spif_top #(
  parameter int num_rt_entries = 4,
  parameter int mp_shift_bits  = 5
) (
  input  wire                  tl_freerun_clk_int,
  input  wire                  tl_reset_all_int,

  input  wire                  link_up,

  // sensor events
  input  spif_pkg::evt_t       evt_data_0,
  input  wire                  evt_vld_0,
  output logic                 evt_rdy_0,
  input  spif_pkg::evt_t       evt_data_1,
  input  wire                  evt_vld_1,
  output logic                 evt_rdy_1,

  // configuration writes
  input  wire                  cfg_wr_en,
  input  spif_pkg::reg_addr_t  cfg_addr,
  input  spif_pkg::reg_data_t  cfg_wdata,

  // link channels
  output spif_pkg::pkt_key_t   chan_data_0,
  output logic                 chan_vld_0,
  input  wire                  chan_rdy_0,
  output spif_pkg::pkt_key_t   chan_data_1,
  output logic                 chan_vld_1,
  input  wire                  chan_rdy_1,

  output spif_pkg::drop_cnt_t  drop_count
);

  // --------------------
  // internal wiring
  // --------------------
  // configuration
  spif_pkg::pkt_key_t         mp_key [spif_pkg::NUM_PIPES];
  spif_pkg::pkt_key_t         mp_msk [spif_pkg::NUM_PIPES];
  logic [mp_shift_bits - 1:0] mp_sft [spif_pkg::NUM_PIPES];
  spif_pkg::pkt_key_t         rt_key [num_rt_entries];
  spif_pkg::pkt_key_t         rt_msk [num_rt_entries];
  spif_pkg::chan_t            rt_rte [num_rt_entries];

  // mapper outputs
  spif_pkg::pkt_key_t map_data_0;
  logic               map_vld_0;
  logic               map_rdy_0;
  spif_pkg::pkt_key_t map_data_1;
  logic               map_vld_1;
  logic               map_rdy_1;

  // shared bus
  spif_pkg::pkt_key_t bus_data;
  logic               bus_vld;
  logic               bus_rdy;

  logic               drop_pulse;

  cfg_reg_bank #(
    .num_rt_entries (num_rt_entries),
    .mp_shift_bits  (mp_shift_bits)
  ) i_cfg_reg_bank (
    .tl_freerun_clk_int (tl_freerun_clk_int),
    .tl_reset_all_int   (tl_reset_all_int),
    .cfg_wr_en          (cfg_wr_en),
    .cfg_addr           (cfg_addr),
    .cfg_wdata          (cfg_wdata),
    .drop_pulse         (drop_pulse),
    .mp_key             (mp_key),
    .mp_msk             (mp_msk),
    .mp_sft             (mp_sft),
    .rt_key             (rt_key),
    .rt_msk             (rt_msk),
    .rt_rte             (rt_rte),
    .drop_count         (drop_count)
  );

  // --------------------
  // event pipes
  // --------------------
  evt_mapper #(
    .mp_shift_bits (mp_shift_bits)
  ) i_evt_mapper_0 (
    .tl_freerun_clk_int (tl_freerun_clk_int),
    .tl_reset_all_int   (tl_reset_all_int),
    .link_up            (link_up),
    .evt_data           (evt_data_0),
    .evt_vld            (evt_vld_0),
    .evt_rdy            (evt_rdy_0),
    .mp_key             (mp_key[0]),
    .mp_msk             (mp_msk[0]),
    .mp_sft             (mp_sft[0]),
    .map_data           (map_data_0),
    .map_vld            (map_vld_0),
    .map_rdy            (map_rdy_0)
  );

  evt_mapper #(
    .mp_shift_bits (mp_shift_bits)
  ) i_evt_mapper_1 (
    .tl_freerun_clk_int (tl_freerun_clk_int),
    .tl_reset_all_int   (tl_reset_all_int),
    .link_up            (link_up),
    .evt_data           (evt_data_1),
    .evt_vld            (evt_vld_1),
    .evt_rdy            (evt_rdy_1),
    .mp_key             (mp_key[1]),
    .mp_msk             (mp_msk[1]),
    .mp_sft             (mp_sft[1]),
    .map_data           (map_data_1),
    .map_vld            (map_vld_1),
    .map_rdy            (map_rdy_1)
  );

  pkt_rr_arbiter i_pkt_rr_arbiter (
    .tl_freerun_clk_int (tl_freerun_clk_int),
    .tl_reset_all_int   (tl_reset_all_int),
    .map_data_0         (map_data_0),
    .map_vld_0          (map_vld_0),
    .map_rdy_0          (map_rdy_0),
    .map_data_1         (map_data_1),
    .map_vld_1          (map_vld_1),
    .map_rdy_1          (map_rdy_1),
    .bus_data           (bus_data),
    .bus_vld            (bus_vld),
    .bus_rdy            (bus_rdy)
  );

  // router to link channels
  pkt_router #(
    .num_rt_entries (num_rt_entries)
  ) i_pkt_router (
    .tl_freerun_clk_int (tl_freerun_clk_int),
    .tl_reset_all_int   (tl_reset_all_int),
    .bus_data           (bus_data),
    .bus_vld            (bus_vld),
    .bus_rdy            (bus_rdy),
    .rt_key             (rt_key),
    .rt_msk             (rt_msk),
    .rt_rte             (rt_rte),
    .chan_data_0        (chan_data_0),
    .chan_vld_0         (chan_vld_0),
    .chan_rdy_0         (chan_rdy_0),
    .chan_data_1        (chan_data_1),
    .chan_vld_1         (chan_vld_1),
    .chan_rdy_1         (chan_rdy_1),
    .drop_pulse         (drop_pulse)
  );

endmodule

`default_nettype wire

//--- pkt_router/pkt_router.sv
/*
  key/mask packet router
  looks up each bus packet in the routing table, lowest matching
  entry wins. matched packets go to a per-channel output register,
  unmatched ones are dropped with a one-cycle drop strobe.
*/

`timescale 1ns/1ns
`default_nettype none

module pkt_router #(
  parameter int num_rt_entries = 4
) (
  input  wire                 tl_freerun_clk_int,
  input  wire                 tl_reset_all_int,

  // packet bus from arbiter
  input  spif_pkg::pkt_key_t  bus_data,
  input  wire                 bus_vld,
  output logic                bus_rdy,

  // routing table
  input  spif_pkg::pkt_key_t  rt_key [num_rt_entries],
  input  spif_pkg::pkt_key_t  rt_msk [num_rt_entries],
  input  spif_pkg::chan_t     rt_rte [num_rt_entries],

  // link channels
  output spif_pkg::pkt_key_t  chan_data_0,
  output logic                chan_vld_0,
  input  wire                 chan_rdy_0,
  output spif_pkg::pkt_key_t  chan_data_1,
  output logic                chan_vld_1,
  input  wire                 chan_rdy_1,

  output logic                drop_pulse
);

  spif_pkg::rtr_state_t state;

  // lookup result
  logic                 hit;
  spif_pkg::chan_t      hit_chan;

  // held packet
  spif_pkg::pkt_key_t   hold_data;
  spif_pkg::chan_t      hold_chan;

  // candidate for a channel register
  spif_pkg::pkt_key_t   sel_data;
  spif_pkg::chan_t      sel_chan;
  logic                 sel_go;
  logic                 fwd;

  // channel registers
  spif_pkg::pkt_key_t   ch_data [spif_pkg::NUM_CHANS];
  logic [spif_pkg::NUM_CHANS - 1:0] ch_vld;
  logic [spif_pkg::NUM_CHANS - 1:0] ch_rdy;
  logic [spif_pkg::NUM_CHANS - 1:0] ch_free;

  assign ch_rdy  = {chan_rdy_1, chan_rdy_0};
  assign ch_free = ~ch_vld | ch_rdy;

  // --------------------
  // table lookup
  // --------------------
  // walk down so the lowest index is written last
  always_comb
  begin
    hit      = 1'b0;
    hit_chan = '0;
    for (int i = num_rt_entries - 1; i >= 0; i--)
    begin
      if ((bus_data & rt_msk[i]) == rt_key[i])
      begin
        hit      = 1'b1;
        hit_chan = rt_rte[i];
      end
    end
  end

  // bus only accepted while nothing is held
  assign bus_rdy    = (state == spif_pkg::RTR_IDLE);
  assign drop_pulse = bus_vld && bus_rdy && !hit;

  // held packet takes priority over the bus
  always_comb
  begin
    if (state == spif_pkg::RTR_HOLD)
    begin
      sel_data = hold_data;
      sel_chan = hold_chan;
      sel_go   = 1'b1;
    end
    else
    begin
      sel_data = bus_data;
      sel_chan = hit_chan;
      sel_go   = bus_vld && hit;
    end
  end

  assign fwd = sel_go && ch_free[sel_chan];

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
      state <= spif_pkg::RTR_IDLE;
    else if (sel_go && !fwd)
      state <= spif_pkg::RTR_HOLD;
    else if (fwd)
      state <= spif_pkg::RTR_IDLE;
  end

  // capture a matched packet whose channel is busy
  always_ff @(posedge tl_freerun_clk_int)
  begin
    if ((state == spif_pkg::RTR_IDLE) && sel_go && !fwd)
    begin
      hold_data <= bus_data;
      hold_chan <= hit_chan;
    end
  end

  // channel output registers
  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
      ch_vld <= '0;
    else
    begin
      for (int c = 0; c < spif_pkg::NUM_CHANS; c++)
      begin
        if (fwd && (sel_chan == spif_pkg::chan_t'(c)))
          ch_vld[c] <= 1'b1;
        else if (ch_rdy[c])
          ch_vld[c] <= 1'b0;
      end
    end
  end

  always_ff @(posedge tl_freerun_clk_int)
  begin
    for (int c = 0; c < spif_pkg::NUM_CHANS; c++)
    begin
      if (fwd && (sel_chan == spif_pkg::chan_t'(c)))
        ch_data[c] <= sel_data;
    end
  end

  assign chan_data_0 = ch_data[0];
  assign chan_vld_0  = ch_vld[0];
  assign chan_data_1 = ch_data[1];
  assign chan_vld_1  = ch_vld[1];

  // stalled channel packets must not change
  a_chan_stable_0: assert property (
    @(posedge tl_freerun_clk_int) disable iff (tl_reset_all_int)
    (chan_vld_0 && !chan_rdy_0) |=> (chan_vld_0 && $stable(chan_data_0))
  );

  a_chan_stable_1: assert property (
    @(posedge tl_freerun_clk_int) disable iff (tl_reset_all_int)
    (chan_vld_1 && !chan_rdy_1) |=> (chan_vld_1 && $stable(chan_data_1))
  );

endmodule

`default_nettype wire

//--- logic/pkt_rr_arbiter.sv
/*
  round-robin packet arbiter
  merges the two event pipes onto the shared packet bus
  through a one-entry output register
*/

`timescale 1ns/1ns
`default_nettype none

module pkt_rr_arbiter (
  input  wire                 tl_freerun_clk_int,
  input  wire                 tl_reset_all_int,

  // pipe 0
  input  spif_pkg::pkt_key_t  map_data_0,
  input  wire                 map_vld_0,
  output logic                map_rdy_0,

  // pipe 1
  input  spif_pkg::pkt_key_t  map_data_1,
  input  wire                 map_vld_1,
  output logic                map_rdy_1,

  // shared bus to router
  output spif_pkg::pkt_key_t  bus_data,
  output logic                bus_vld,
  input  wire                 bus_rdy
);

  // last granted pipe (1 = pipe 1)
  logic last_grant;
  logic pick_1;
  logic bus_free;
  logic take_0;
  logic take_1;

  // --------------------
  // grant
  // --------------------
  // pipe 1 wins alone, or on a tie when pipe 0 went last
  assign pick_1   = map_vld_1 && (!map_vld_0 || !last_grant);
  assign bus_free = !bus_vld || bus_rdy;

  assign map_rdy_0 = bus_free && !pick_1;
  assign map_rdy_1 = bus_free && pick_1;

  assign take_0 = map_vld_0 && map_rdy_0;
  assign take_1 = map_vld_1 && map_rdy_1;

  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
    begin
      // pipe 0 first after reset
      last_grant <= 1'b1;
      bus_vld    <= 1'b0;
    end
    else
    begin
      if (take_1)
        last_grant <= 1'b1;
      else if (take_0)
        last_grant <= 1'b0;

      if (take_0 || take_1)
        bus_vld <= 1'b1;
      else if (bus_rdy)
        bus_vld <= 1'b0;
    end
  end

  // bus payload
  always_ff @(posedge tl_freerun_clk_int)
  begin
    if (take_0 || take_1)
      bus_data <= pick_1 ? map_data_1 : map_data_0;
  end

  // stalled bus packet must not change
  a_bus_stable: assert property (
    @(posedge tl_freerun_clk_int) disable iff (tl_reset_all_int)
    (bus_vld && !bus_rdy) |=> (bus_vld && $stable(bus_data))
  );

endmodule

`default_nettype wire

//--- logic/evt_mapper.sv
/*
  event mapper
  turns a raw sensor event into a spinnaker packet key
  (masked, shifted right, then merged with the pipe key) and
  holds it in a one-entry output register. swallows events
  while the link is down.
*/

`timescale 1ns/1ns
`default_nettype none

module evt_mapper #(
  parameter int mp_shift_bits = 5
) (
  input  wire                         tl_freerun_clk_int,
  input  wire                         tl_reset_all_int,

  // link handshake done
  input  wire                         link_up,

  // incoming event
  input  spif_pkg::evt_t              evt_data,
  input  wire                         evt_vld,
  output logic                        evt_rdy,

  // mapper configuration
  input  spif_pkg::pkt_key_t          mp_key,
  input  spif_pkg::pkt_key_t          mp_msk,
  input  wire [mp_shift_bits - 1:0]   mp_sft,

  // mapped packet key
  output spif_pkg::pkt_key_t          map_data,
  output logic                        map_vld,
  input  wire                         map_rdy
);

  spif_pkg::pkt_key_t map_key;
  logic               evt_load;

  // key formation
  assign map_key = ((evt_data & mp_msk) >> mp_sft) | mp_key;

  // --------------------
  // handshake
  // --------------------
  // link down: always ready, events go nowhere
  assign evt_rdy  = !link_up || !map_vld || map_rdy;
  assign evt_load = evt_vld && evt_rdy && link_up;

  // output register valid
  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
      map_vld <= 1'b0;
    else if (evt_load)
      map_vld <= 1'b1;
    else if (map_rdy)
      map_vld <= 1'b0;
  end

  // payload
  always_ff @(posedge tl_freerun_clk_int)
  begin
    if (evt_load)
      map_data <= map_key;
  end

  // stalled key must not change, even with link toggling
  a_map_stable: assert property (
    @(posedge tl_freerun_clk_int) disable iff (tl_reset_all_int)
    (map_vld && !map_rdy) |=> (map_vld && $stable(map_data))
  );

endmodule

`default_nettype wire

//--- logic/cfg_reg_bank.sv
/*
  configuration register bank
  decodes strobe writes into the mapper and routing table registers
  and keeps the saturating count of dropped packets
*/

`timescale 1ns/1ns
`default_nettype none

module cfg_reg_bank #(
  parameter int num_rt_entries = 4,
  parameter int mp_shift_bits  = 5
) (
  input  wire                  tl_freerun_clk_int,
  input  wire                  tl_reset_all_int,

  // write strobe
  input  wire                  cfg_wr_en,
  input  spif_pkg::reg_addr_t  cfg_addr,
  input  spif_pkg::reg_data_t  cfg_wdata,

  // drop event from router
  input  wire                  drop_pulse,

  // mapper registers
  output spif_pkg::pkt_key_t   mp_key [spif_pkg::NUM_PIPES],
  output spif_pkg::pkt_key_t   mp_msk [spif_pkg::NUM_PIPES],
  output logic [mp_shift_bits - 1:0] mp_sft [spif_pkg::NUM_PIPES],

  // routing table
  output spif_pkg::pkt_key_t   rt_key [num_rt_entries],
  output spif_pkg::pkt_key_t   rt_msk [num_rt_entries],
  output spif_pkg::chan_t      rt_rte [num_rt_entries],

  output spif_pkg::drop_cnt_t  drop_count
);

  // --------------------
  // mapper registers
  // --------------------
  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
    begin
      for (int p = 0; p < spif_pkg::NUM_PIPES; p++)
      begin
        mp_key[p] <= '0;
        mp_msk[p] <= '0;
        mp_sft[p] <= '0;
      end
    end
    else if (cfg_wr_en)
    begin
      // per-pipe offset from each base
      for (int p = 0; p < spif_pkg::NUM_PIPES; p++)
      begin
        if (cfg_addr == spif_pkg::reg_addr_t'(spif_pkg::MP_KEY_BASE + p))
          mp_key[p] <= cfg_wdata;
        if (cfg_addr == spif_pkg::reg_addr_t'(spif_pkg::MP_MSK_BASE + p))
          mp_msk[p] <= cfg_wdata;
        // shift amount keeps low bits only
        if (cfg_addr == spif_pkg::reg_addr_t'(spif_pkg::MP_SFT_BASE + p))
          mp_sft[p] <= cfg_wdata[mp_shift_bits - 1:0];
      end
    end
  end

  // --------------------
  // routing table
  // --------------------
  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
    begin
      // all zero: every entry matches, route to channel 0
      for (int e = 0; e < num_rt_entries; e++)
      begin
        rt_key[e] <= '0;
        rt_msk[e] <= '0;
        rt_rte[e] <= '0;
      end
    end
    else if (cfg_wr_en)
    begin
      for (int e = 0; e < num_rt_entries; e++)
      begin
        if (cfg_addr == spif_pkg::reg_addr_t'(spif_pkg::RT_KEY_BASE + e))
          rt_key[e] <= cfg_wdata;
        if (cfg_addr == spif_pkg::reg_addr_t'(spif_pkg::RT_MSK_BASE + e))
          rt_msk[e] <= cfg_wdata;
        if (cfg_addr == spif_pkg::reg_addr_t'(spif_pkg::RT_RTE_BASE + e))
          rt_rte[e] <= spif_pkg::chan_t'(cfg_wdata);
      end
    end
  end

  // drop counter, sticks at all ones
  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
      drop_count <= '0;
    else if (drop_pulse && (drop_count != '1))
      drop_count <= drop_count + 1'b1;
  end

endmodule

`default_nettype wire

//--- common/spif_pkg.sv
/*
  spif shared definitions
  widths for events, packet keys and configuration words,
  register address map and router FSM states
*/

`default_nettype none

package spif_pkg;

  // --------------------
  // data widths
  // --------------------
  // raw sensor event
  typedef logic [31:0] evt_t;
  // spinnaker packet key
  typedef logic [31:0] pkt_key_t;

  // configuration port
  typedef logic  [5:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // outgoing channel index
  typedef logic  [0:0] chan_t;

  // dropped packets, saturating
  typedef logic [15:0] drop_cnt_t;

  // two-way arbiter, two link channels
  localparam int NUM_PIPES = 2;
  localparam int NUM_CHANS = 2;

  // --------------------
  // register map
  // --------------------
  // mapper registers, one per pipe
  localparam reg_addr_t MP_KEY_BASE = 6'd0;
  localparam reg_addr_t MP_MSK_BASE = 6'd2;
  localparam reg_addr_t MP_SFT_BASE = 6'd4;

  // routing table, one per entry (up to 8)
  localparam reg_addr_t RT_KEY_BASE = 6'd16;
  localparam reg_addr_t RT_MSK_BASE = 6'd24;
  localparam reg_addr_t RT_RTE_BASE = 6'd32;

  // router FSM
  // hold = matched packet waiting for its channel register
  typedef enum logic {
    RTR_IDLE,
    RTR_HOLD
  } rtr_state_t;

endpackage

`default_nettype wire
